/* verilog/aluPkg.sv */
package aluPkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand and result width
  localparam int WORD_W = 32;

  // --------------------------------------------------
  // opcodes
  // --------------------------------------------------

  // three bit opcode, arithmetic first then bitwise
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    // signed compare, result is 0 or 1
    OP_SLT  = 3'd2,
    OP_NAND = 3'd3,
    OP_NOR  = 3'd4,
    OP_XOR  = 3'd5,
    OP_XNOR = 3'd6,
    // inverts operandA, operandB unused
    OP_INV  = 3'd7
  } aluOpE;

  // --------------------------------------------------
  // adder output
  // --------------------------------------------------

  // raw ripple adder output before result select
  typedef struct packed {
    logic [WORD_W-1:0] sum;
    // carry out of the top stage
    logic              carry;
    // carry into top bit xor carry out of it
    logic              overflow;
  } arithResT;

endpackage

/* verilog/aluDataIf.sv */
`timescale 1ns/1ps

// latched request from control to the datapath blocks
interface aluDataIf;

  // --------------------------------------------------
  // latched request
  // --------------------------------------------------

  // operands, held stable for the whole operation
  logic [aluPkg::WORD_W-1:0] operandA;
  logic [aluPkg::WORD_W-1:0] operandB;

  // opcode of the operation in flight
  aluPkg::aluOpE             op;

  // one cycle strobe, result stage captures on it
  logic                      load;

  // --------------------------------------------------
  // modports
  // --------------------------------------------------

  // control side owns everything
  modport ctrl (
    output operandA,
    output operandB,
    output op,
    output load
  );

  // adder, logic unit and result stage only look
  modport dp (
    input  operandA,
    input  operandB,
    input  op,
    input  load
  );

endinterface

/* verilog/aluCtrl.sv */
`timescale 1ns/1ps

module aluCtrl (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      req,
  input  aluPkg::aluOpE             op,
  input  logic [aluPkg::WORD_W-1:0] operandA,
  input  logic [aluPkg::WORD_W-1:0] operandB,
  output logic                      ack,
  aluDataIf.ctrl                    dataIf
);

  // --------------------------------------------------
  // handshake fsm
  // --------------------------------------------------

  // idle -> exec -> load -> ack -> idle
  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    LOAD,
    ACK
  } ctrlStateE;

  ctrlStateE state;
  ctrlStateE stateNext;

  // request accepted this cycle
  logic      take;

  assign take = (state == IDLE) && req;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (req) begin
          stateNext = EXEC;
        end
      end
      // datapath settles on the latched operands
      EXEC: stateNext = LOAD;
      LOAD: stateNext = ACK;
      // hold until the requester lets go
      ACK: begin
        if (!req) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= IDLE;
      dataIf.load <= 1'b0;
      ack         <= 1'b0;
    end else begin
      state       <= stateNext;
      // strobe high for exactly the load state
      dataIf.load <= (state == EXEC);
      // ack lines up with the result register update
      ack         <= (stateNext == ACK);
    end
  end

  // --------------------------------------------------
  // operand latch
  // --------------------------------------------------

  // capture once per request, later input changes ignored
  always_ff @(posedge clk) begin
    if (take) begin
      dataIf.operandA <= operandA;
      dataIf.operandB <= operandB;
      dataIf.op       <= op;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // ack only comes up on an edge that saw req high
  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    (!req && !ack) |=> !ack)
    else $error("ack rose with no request pending");

  // load is a single cycle strobe
  loadOnePulse: assert property (@(posedge clk) disable iff (!rstN)
    dataIf.load |=> !dataIf.load)
    else $error("load held for two cycles");

endmodule

/* verilog/aluAddSub.sv */
`timescale 1ns/1ps

module aluAddSub (
  aluDataIf.dp             dataIf,
  output aluPkg::arithResT res
);

  // --------------------------------------------------
  // mode
  // --------------------------------------------------

  // slt is a subtract, the result stage looks at the sign
  logic                      sub;

  // b after conditional inversion
  logic [aluPkg::WORD_W-1:0] bIn;

  // carry chain, c[0] is the carry in
  logic [aluPkg::WORD_W:0]   c;

  // per stage sum bits
  logic [aluPkg::WORD_W-1:0] sumBits;

  assign sub  = (dataIf.op == aluPkg::OP_SUB) || (dataIf.op == aluPkg::OP_SLT);

  // two's complement, invert b and carry in a one
  assign c[0] = sub;

  // --------------------------------------------------
  // ripple chain
  // --------------------------------------------------

  for (genvar i = 0; i < aluPkg::WORD_W; i++) begin : gStage
    logic a;
    logic b;
    logic cIn;

    assign a   = dataIf.operandA[i];
    assign cIn = c[i];

    // flip b when subtracting
    assign bIn[i] = dataIf.operandB[i] ^ sub;
    assign b      = bIn[i];

    // full adder
    assign sumBits[i] = a ^ b ^ cIn;
    // majority of the three inputs
    assign c[i+1]     = (a & b) | (a & cIn) | (b & cIn);
  end

  // --------------------------------------------------
  // output
  // --------------------------------------------------

  assign res.sum      = sumBits;
  // for sub a high carry means no borrow
  assign res.carry    = c[aluPkg::WORD_W];
  // signed overflow from the last two carries
  assign res.overflow = c[aluPkg::WORD_W] ^ c[aluPkg::WORD_W-1];

endmodule

/* verilog/aluLogic.sv */
`timescale 1ns/1ps

module aluLogic (
  aluDataIf.dp                      dataIf,
  output logic [aluPkg::WORD_W-1:0] logicRes
);

  // --------------------------------------------------
  // bitwise slice
  // --------------------------------------------------

  // one slice per bit, same select on every slice
  for (genvar i = 0; i < aluPkg::WORD_W; i++) begin : gBit
    logic a;
    logic b;
    logic bitRes;

    assign a = dataIf.operandA[i];
    assign b = dataIf.operandB[i];

    always_comb begin
      case (dataIf.op)
        aluPkg::OP_NAND: bitRes = ~(a & b);
        aluPkg::OP_NOR:  bitRes = ~(a | b);
        aluPkg::OP_XOR:  bitRes = a ^ b;
        aluPkg::OP_XNOR: bitRes = ~(a ^ b);
        // single operand, b ignored
        aluPkg::OP_INV:  bitRes = ~a;
        // add, sub and slt come from the adder
        default:         bitRes = 1'b0;
      endcase
    end

    assign logicRes[i] = bitRes;
  end

endmodule

/* verilog/aluResult.sv */
`timescale 1ns/1ps

module aluResult (
  input  logic                      clk,
  input  logic                      rstN,
  aluDataIf.dp                      dataIf,
  input  aluPkg::arithResT          arith,
  input  logic [aluPkg::WORD_W-1:0] logicRes,
  output logic [aluPkg::WORD_W-1:0] result,
  output logic                      carry,
  output logic                      overflow,
  output logic                      zero
);

  // --------------------------------------------------
  // select
  // --------------------------------------------------

  logic [aluPkg::WORD_W-1:0] resultNext;
  logic                      isArith;
  // signed a < b, corrected for overflow
  logic                      sltBit;

  assign isArith = (dataIf.op == aluPkg::OP_ADD) || (dataIf.op == aluPkg::OP_SUB);
  assign sltBit  = arith.sum[aluPkg::WORD_W-1] ^ arith.overflow;

  always_comb begin
    case (dataIf.op)
      aluPkg::OP_ADD,
      aluPkg::OP_SUB: resultNext = arith.sum;
      // only bit 0 carries the answer
      aluPkg::OP_SLT: resultNext = {{(aluPkg::WORD_W-1){1'b0}}, sltBit};
      default:        resultNext = logicRes;
    endcase
  end

  // --------------------------------------------------
  // output register
  // --------------------------------------------------

  // holds between loads, so back pressure keeps the value
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result   <= '0;
      carry    <= 1'b0;
      overflow <= 1'b0;
      zero     <= 1'b0;
    end else if (dataIf.load) begin
      result   <= resultNext;
      // adder flags only for plain add and sub
      carry    <= isArith & arith.carry;
      overflow <= isArith & arith.overflow;
      // flag follows the registered value
      zero     <= (resultNext == '0);
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // compare result is the signed order of the latched operands, upper bits clear
  sltValue: assert property (@(posedge clk) disable iff (!rstN)
    (dataIf.load && dataIf.op == aluPkg::OP_SLT)
    |=> (result == {{(aluPkg::WORD_W-1){1'b0}},
                    ($signed($past(dataIf.operandA)) < $signed($past(dataIf.operandB)))}))
    else $error("slt result wrong or upper bits set");

endmodule

/* verilog/aluTop.sv */
`timescale 1ns/1ps

module aluTop (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      req,
  input  aluPkg::aluOpE             op,
  input  logic [aluPkg::WORD_W-1:0] operandA,
  input  logic [aluPkg::WORD_W-1:0] operandB,
  output logic                      ack,
  output logic [aluPkg::WORD_W-1:0] result,
  output logic                      carry,
  output logic                      overflow,
  output logic                      zero
);

  // --------------------------------------------------
  // internal links
  // --------------------------------------------------

  // latched request shared by all datapath blocks
  aluDataIf dataIf ();

  // adder to result stage
  aluPkg::arithResT          arith;
  // logic unit to result stage
  logic [aluPkg::WORD_W-1:0] logicRes;

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------

  aluCtrl u_ctrl (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .op       (op),
    .operandA (operandA),
    .operandB (operandB),
    .ack      (ack),
    .dataIf   (dataIf.ctrl)
  );

  aluAddSub u_addSub (
    .dataIf (dataIf.dp),
    .res    (arith)
  );

  aluLogic u_logic (
    .dataIf   (dataIf.dp),
    .logicRes (logicRes)
  );

  aluResult u_result (
    .clk      (clk),
    .rstN     (rstN),
    .dataIf   (dataIf.dp),
    .arith    (arith),
    .logicRes (logicRes),
    .result   (result),
    .carry    (carry),
    .overflow (overflow),
    .zero     (zero)
  );

endmodule

/* include/aluModel.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// --------------------------------------------------
// random source
// --------------------------------------------------

// plain lcg, state updated in place
function automatic logic [31:0] lcgNext(inout logic [31:0] seed);
  seed = seed * 32'd1664525 + 32'd1013904223;
  return seed;
endfunction

// --------------------------------------------------
// reference model
// --------------------------------------------------

// wide sum, top bit is the carry out
function automatic logic [aluPkg::WORD_W:0] modelSum(
  input aluPkg::aluOpE             op,
  input logic [aluPkg::WORD_W-1:0] a,
  input logic [aluPkg::WORD_W-1:0] b
);
  if (op == aluPkg::OP_SUB || op == aluPkg::OP_SLT) begin
    return {1'b0, a} + {1'b0, ~b} + 1'b1;
  end
  return {1'b0, a} + {1'b0, b};
endfunction

// expected result word for any opcode
function automatic logic [aluPkg::WORD_W-1:0] modelResult(
  input aluPkg::aluOpE             op,
  input logic [aluPkg::WORD_W-1:0] a,
  input logic [aluPkg::WORD_W-1:0] b
);
  logic [aluPkg::WORD_W:0] s;
  s = modelSum(op, a, b);
  case (op)
    aluPkg::OP_ADD,
    aluPkg::OP_SUB:  return s[aluPkg::WORD_W-1:0];
    aluPkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
    aluPkg::OP_NAND: return ~(a & b);
    aluPkg::OP_NOR:  return ~(a | b);
    aluPkg::OP_XOR:  return a ^ b;
    aluPkg::OP_XNOR: return ~(a ^ b);
    default:         return ~a;
  endcase
endfunction

// carry flag, add and sub only
function automatic logic modelCarry(
  input aluPkg::aluOpE             op,
  input logic [aluPkg::WORD_W-1:0] a,
  input logic [aluPkg::WORD_W-1:0] b
);
  logic [aluPkg::WORD_W:0] s;
  s = modelSum(op, a, b);
  return (op == aluPkg::OP_ADD || op == aluPkg::OP_SUB) && s[aluPkg::WORD_W];
endfunction

// signed overflow from operand and result signs
function automatic logic modelOverflow(
  input aluPkg::aluOpE             op,
  input logic [aluPkg::WORD_W-1:0] a,
  input logic [aluPkg::WORD_W-1:0] b
);
  logic [aluPkg::WORD_W:0] s;
  logic                    sa;
  logic                    sb;
  logic                    sr;
  s  = modelSum(op, a, b);
  sa = a[aluPkg::WORD_W-1];
  sb = b[aluPkg::WORD_W-1];
  sr = s[aluPkg::WORD_W-1];
  if (op == aluPkg::OP_ADD) begin
    return (sa == sb) && (sr != sa);
  end
  if (op == aluPkg::OP_SUB) begin
    return (sa != sb) && (sr != sa);
  end
  return 1'b0;
endfunction

`endif

/* bench/aluTb.sv */
`timescale 1ns/1ps

module aluTb;

`include "aluModel.svh"

  // --------------------------------------------------
  // run length
  // --------------------------------------------------

  localparam int NUM_RAND    = 300;
  localparam int NUM_DIRECT  = 7;
  localparam int NUM_OPS     = NUM_RAND + NUM_DIRECT;
  // two spare op slots cover reset and the idle stretch
  localparam int WATCHDOG_NS = (NUM_OPS + 2) * 20 * 8;
  // give up on an ack after this many edges
  localparam int ACK_LIMIT   = 10;

  logic                      clk;
  logic                      rstN;
  logic                      req;
  aluPkg::aluOpE             op;
  logic [aluPkg::WORD_W-1:0] operandA;
  logic [aluPkg::WORD_W-1:0] operandB;
  logic                      ack;
  logic [aluPkg::WORD_W-1:0] result;
  logic                      carry;
  logic                      overflow;
  logic                      zero;

  logic [31:0]               seed;
  int                        errors;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  aluTop u_aluTop (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .op       (op),
    .operandA (operandA),
    .operandB (operandB),
    .ack      (ack),
    .result   (result),
    .carry    (carry),
    .overflow (overflow),
    .zero     (zero)
  );

  // --------------------------------------------------
  // check helpers
  // --------------------------------------------------

  task automatic reportFailure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // all four outputs against the model, zero follows the result
  task automatic checkOutputs(
    input logic [aluPkg::WORD_W-1:0] expRes,
    input logic                      expC,
    input logic                      expV
  );
    checkWord("result", expRes, result);
    checkFlag("carry", expC, carry);
    checkFlag("overflow", expV, overflow);
    checkFlag("zero", expRes == '0, zero);
  endtask

  // --------------------------------------------------
  // requester
  // --------------------------------------------------

  // one full four phase transfer, req held for hold extra edges after ack
  task automatic doOperation(
    input aluPkg::aluOpE             opIn,
    input logic [aluPkg::WORD_W-1:0] a,
    input logic [aluPkg::WORD_W-1:0] b,
    input int                        hold
  );
    logic [aluPkg::WORD_W-1:0] expRes;
    logic                      expC;
    logic                      expV;
    logic [31:0]               r;
    int                        edges;
    expRes   = modelResult(opIn, a, b);
    expC     = modelCarry(opIn, a, b);
    expV     = modelOverflow(opIn, a, b);
    // called 1 ns past an edge
    op       = opIn;
    operandA = a;
    operandB = b;
    req      = 1'b1;
    edges    = 0;
    while (!ack && edges < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (!ack) begin
      reportFailure($sformatf("no ack within %0d cycles of req", ACK_LIMIT));
      req = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      return;
    end
    // latch edge, load edge, then ack with the result
    if (edges != 3) begin
      reportFailure($sformatf("ack came %0d edges after req, expected 3", edges));
    end
    checkOutputs(expRes, expC, expV);
    // back pressure, operands wander but the result must hold
    for (int i = 0; i < hold; i++) begin
      r        = lcgNext(seed);
      operandA = r;
      operandB = ~r;
      @(posedge clk);
      #1;
      if (!ack) begin
        reportFailure("ack dropped while req was still held");
      end
      checkOutputs(expRes, expC, expV);
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    if (ack) begin
      reportFailure("ack still high on the edge after req dropped");
    end
    checkOutputs(expRes, expC, expV);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    logic [31:0]   r;
    logic [31:0]   a;
    logic [31:0]   b;
    aluPkg::aluOpE rOp;
    int            hold;
    seed     = 32'h1811;
    errors   = 0;
    rstN     = 1'b0;
    req      = 1'b0;
    op       = aluPkg::OP_ADD;
    operandA = '0;
    operandB = '0;
    repeat (8) @(posedge clk);
    #1;
    checkFlag("ack", 1'b0, ack);
    checkWord("result", '0, result);
    checkFlag("carry", 1'b0, carry);
    checkFlag("overflow", 1'b0, overflow);
    checkFlag("zero", 1'b0, zero);
    rstN = 1'b1;
    // quiet bus, nothing may start
    repeat (10) begin
      @(posedge clk);
      #1;
      if (ack) begin
        reportFailure("ack rose while req stayed low after reset");
      end
    end

    // adder corners
    doOperation(aluPkg::OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 1);
    doOperation(aluPkg::OP_SUB, 32'h0000_0000, 32'h0000_0001, 0);
    doOperation(aluPkg::OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 2);
    // signed compare corners, bare sign gets these wrong
    doOperation(aluPkg::OP_SLT, 32'h8000_0000, 32'h0000_0001, 0);
    doOperation(aluPkg::OP_SLT, 32'h7FFF_FFFF, 32'h8000_0000, 1);
    doOperation(aluPkg::OP_SLT, 32'h0000_0001, 32'h8000_0000, 0);
    doOperation(aluPkg::OP_SLT, 32'h0000_0005, 32'h0000_0005, 3);

    for (int n = 0; n < NUM_RAND; n++) begin
      r    = lcgNext(seed);
      // upper lcg bits are the better ones
      rOp  = aluPkg::aluOpE'(r[30:28]);
      a    = lcgNext(seed);
      b    = lcgNext(seed);
      r    = lcgNext(seed);
      hold = int'(r[29:28]);
      doOperation(rOp, a, b, hold);
    end

    $display("errors: %0d over %0d operations", errors, NUM_OPS);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR at %0t: run hung, watchdog expired before the last operation", $time);
    $display("errors: %0d plus the hang", errors);
    $display("Test failures found");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
verilog/aluPkg.sv
verilog/aluDataIf.sv
verilog/aluCtrl.sv
verilog/aluAddSub.sv
verilog/aluLogic.sv
verilog/aluResult.sv
verilog/aluTop.sv
bench/aluTb.sv

/* run.sh */
#!/bin/sh
# build the ALU testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module aluTb -o aluSim \
  && ./obj_dir/aluSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q 'Test failures found' sim.log && { echo "FAIL"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "no pass line in the log"; exit 1; }
echo "PASS"
